//--- hw/bus_pkg.sv
`default_nettype none

`include "cache_params.svh"

package bus_pkg;

    // command handed to the memory port
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_READ,
        BUS_WRITE
    } bus_cmd_t;

    typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

    // word 0 sits in the low bits
    typedef logic [`LINE_WIDTH-1:0]     line_t;

endpackage

`default_nettype wire

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module cache_ctrl (
    input  wire logic                   clk,
    input  wire logic                   proc_reset,
    input  wire logic                   proc_read,
    input  wire logic                   proc_write,
    input  wire cache_pkg::proc_addr_t  proc_addr,
    input  wire cache_pkg::word_t       proc_wdata,
    output logic                        proc_stall,
    output cache_pkg::word_t            proc_rdata,
    input  wire logic                   hit,
    input  wire logic                   dirty,
    input  wire bus_pkg::line_t         line_data,
    output cache_pkg::index_t           index,
    output cache_pkg::tag_t             req_tag,
    output cache_pkg::offset_t          word_sel,
    output logic                        fill_en,
    output logic                        word_wr_en,
    output cache_pkg::word_t            wr_word,
    output bus_pkg::bus_cmd_t           bus_cmd,
    output bus_pkg::mem_addr_t          req_line_addr,
    input  wire logic                   ready,
    input  wire bus_pkg::line_t         fill_data
);
    import cache_pkg::*;
    import bus_pkg::*;

    logic        read_q;
    logic        write_q;
    proc_addr_t  addr_q;
    word_t       wdata_q;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        stall_next;
    word_t       rdata_next;

    function automatic word_t pick_word(input line_t line, input offset_t sel);
        return line[sel*`WORD_WIDTH +: `WORD_WIDTH];
    endfunction

    // processor request one cycle behind the pins
    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            read_q  <= 1'b0;
            write_q <= 1'b0;
        end else begin
            read_q  <= proc_read;
            write_q <= proc_write;
        end
    end

    always_ff @(posedge clk) begin
        addr_q  <= proc_addr;
        wdata_q <= proc_wdata;
    end

    // tag | index | word
    assign req_tag       = addr_q[`PROC_ADDR_WIDTH-1 -: `TAG_WIDTH];
    assign index         = addr_q[`OFFSET_WIDTH +: `INDEX_WIDTH];
    assign word_sel      = addr_q[`OFFSET_WIDTH-1:0];
    assign req_line_addr = addr_q[`PROC_ADDR_WIDTH-1:`OFFSET_WIDTH];
    assign wr_word       = wdata_q;

    // line is loaded on the edge that leaves REFILL
    assign fill_en    = (state == REFILL) && ready;
    assign word_wr_en = (state == RESPOND) && write_q;

    // mem_port registers bus_cmd for the next cycle
    always_comb begin
        state_next = state;
        bus_cmd    = BUS_IDLE;
        stall_next = 1'b1;
        rdata_next = proc_rdata;
        case (state)
            LOOKUP: begin
                if (read_q || write_q) begin
                    if (hit) begin
                        state_next = RESPOND;
                        stall_next = 1'b0;
                        rdata_next = pick_word(line_data, word_sel);
                    end else if (dirty) begin
                        state_next = WRITE_BACK;
                        bus_cmd    = BUS_WRITE;
                    end else begin
                        state_next = REFILL;
                        bus_cmd    = BUS_READ;
                    end
                end
            end
            WRITE_BACK: begin
                if (ready) begin
                    state_next = REFILL;
                    bus_cmd    = BUS_READ;
                end else begin
                    bus_cmd = BUS_WRITE;
                end
            end
            REFILL: begin
                if (ready) begin
                    state_next = RESPOND;
                    stall_next = 1'b0;
                    // answer straight from the returned line
                    rdata_next = pick_word(fill_data, word_sel);
                end else begin
                    bus_cmd = BUS_READ;
                end
            end
            RESPOND: begin
                state_next = SETTLE;
            end
            SETTLE: begin
                state_next = LOOKUP;
            end
            default: begin
                state_next = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state      <= LOOKUP;
            proc_stall <= 1'b1;
        end else begin
            state      <= state_next;
            proc_stall <= stall_next;
        end
    end

    always_ff @(posedge clk) begin
        proc_rdata <= rdata_next;
    end

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_pkg;

    // controller states
    typedef enum logic [2:0] {
        LOOKUP,
        WRITE_BACK,
        REFILL,
        RESPOND,
        SETTLE
    } ctrl_state_t;

    typedef logic [`WORD_WIDTH-1:0]      word_t;
    typedef logic [`TAG_WIDTH-1:0]       tag_t;
    typedef logic [`INDEX_WIDTH-1:0]     index_t;
    typedef logic [`OFFSET_WIDTH-1:0]    offset_t;

    // word address from the processor
    typedef logic [`PROC_ADDR_WIDTH-1:0] proc_addr_t;

endpackage

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  wire logic                   clk,
    input  wire logic                   proc_reset,
    input  wire logic                   proc_read,
    input  wire logic                   proc_write,
    input  wire cache_pkg::proc_addr_t  proc_addr,
    input  wire cache_pkg::word_t       proc_wdata,
    output logic                        proc_stall,
    output cache_pkg::word_t            proc_rdata,
    output logic                        mem_read,
    output logic                        mem_write,
    output bus_pkg::mem_addr_t          mem_addr,
    output bus_pkg::line_t              mem_wdata,
    input  wire logic                   mem_ready,
    input  wire bus_pkg::line_t         mem_rdata
);
    import cache_pkg::*;
    import bus_pkg::*;

    logic      hit;
    logic      dirty;
    logic      fill_en;
    logic      word_wr_en;
    logic      ready;
    index_t    index;
    tag_t      req_tag;
    tag_t      victim_tag;
    offset_t   word_sel;
    word_t     wr_word;
    line_t     line_data;
    line_t     fill_data;
    bus_cmd_t  bus_cmd;
    mem_addr_t req_line_addr;

    cache_ctrl u_ctrl (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .proc_read     (proc_read),
        .proc_write    (proc_write),
        .proc_addr     (proc_addr),
        .proc_wdata    (proc_wdata),
        .proc_stall    (proc_stall),
        .proc_rdata    (proc_rdata),
        .hit           (hit),
        .dirty         (dirty),
        .line_data     (line_data),
        .index         (index),
        .req_tag       (req_tag),
        .word_sel      (word_sel),
        .fill_en       (fill_en),
        .word_wr_en    (word_wr_en),
        .wr_word       (wr_word),
        .bus_cmd       (bus_cmd),
        .req_line_addr (req_line_addr),
        .ready         (ready),
        .fill_data     (fill_data)
    );

    line_store u_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .req_tag    (req_tag),
        .word_sel   (word_sel),
        .fill_en    (fill_en),
        .word_wr_en (word_wr_en),
        .wr_word    (wr_word),
        .fill_data  (fill_data),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag),
        .line_data  (line_data)
    );

    mem_port u_mem (
        .clk           (clk),
        .proc_reset    (proc_reset),
        .bus_cmd       (bus_cmd),
        .req_line_addr (req_line_addr),
        .victim_tag    (victim_tag),
        .index         (index),
        .line_data     (line_data),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .ready         (ready),
        .fill_data     (fill_data)
    );

endmodule

`default_nettype wire

//--- hw/line_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module line_store (
    input  wire logic                clk,
    input  wire logic                proc_reset,
    input  wire cache_pkg::index_t   index,
    input  wire cache_pkg::tag_t     req_tag,
    input  wire cache_pkg::offset_t  word_sel,
    input  wire logic                fill_en,
    input  wire logic                word_wr_en,
    input  wire cache_pkg::word_t    wr_word,
    input  wire bus_pkg::line_t      fill_data,
    output logic                     hit,
    output logic                     dirty,
    output cache_pkg::tag_t          victim_tag,
    output bus_pkg::line_t           line_data
);
    import cache_pkg::*;

    word_t                   data_q [`CACHE_LINES][`WORDS_PER_LINE];
    tag_t                    tag_q  [`CACHE_LINES];
    logic [`CACHE_LINES-1:0] valid_q;
    logic [`CACHE_LINES-1:0] dirty_q;

    // read side has no delay
    always_comb begin
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            line_data[w*`WORD_WIDTH +: `WORD_WIDTH] = data_q[index][w];
        end
    end

    assign victim_tag = tag_q[index];
    assign dirty      = dirty_q[index];

    // tag compare
    assign hit = valid_q[index] && (tag_q[index] == req_tag);

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_q[index] <= req_tag;
            for (int w = 0; w < `WORDS_PER_LINE; w++) begin
                data_q[index][w] <= fill_data[w*`WORD_WIDTH +: `WORD_WIDTH];
            end
        end else if (word_wr_en) begin
            data_q[index][word_sel] <= wr_word;
        end
    end

    // status bits
    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= 1'b0;
        end else if (word_wr_en) begin
            dirty_q[index] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port (
    input  wire logic                clk,
    input  wire logic                proc_reset,
    input  wire bus_pkg::bus_cmd_t   bus_cmd,
    input  wire bus_pkg::mem_addr_t  req_line_addr,
    input  wire cache_pkg::tag_t     victim_tag,
    input  wire cache_pkg::index_t   index,
    input  wire bus_pkg::line_t      line_data,
    output logic                     mem_read,
    output logic                     mem_write,
    output bus_pkg::mem_addr_t       mem_addr,
    output bus_pkg::line_t           mem_wdata,
    input  wire logic                mem_ready,
    input  wire bus_pkg::line_t      mem_rdata,
    output logic                     ready,
    output bus_pkg::line_t           fill_data
);
    import bus_pkg::*;

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            ready     <= 1'b0;
        end else begin
            mem_read  <= (bus_cmd == BUS_READ);
            mem_write <= (bus_cmd == BUS_WRITE);
            ready     <= mem_ready;
        end
    end

    // address and data hold while idle
    always_ff @(posedge clk) begin
        fill_data <= mem_rdata;
        if (bus_cmd == BUS_WRITE) begin
            // victim line goes back to where it came from
            mem_addr  <= {victim_tag, index};
            mem_wdata <= line_data;
        end else if (bus_cmd == BUS_READ) begin
            mem_addr <= req_line_addr;
        end
    end

endmodule

`default_nettype wire

//--- include/cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// cache geometry
`define CACHE_LINES      8
`define WORDS_PER_LINE   4
`define WORD_WIDTH       32

// processor word address split as tag | index | offset
`define PROC_ADDR_WIDTH  30
`define OFFSET_WIDTH     2
`define INDEX_WIDTH      3
`define TAG_WIDTH        25

// memory side moves whole lines
`define MEM_ADDR_WIDTH   28
`define LINE_WIDTH       128

`endif

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f tb.f --top-module tb_cache -o tb_cache_sim
./obj_dir/tb_cache_sim > sim.log 2>&1
cat sim.log

if grep -q "^Test OK$" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb.f
+incdir+include
hw/cache_pkg.sv
hw/bus_pkg.sv
hw/cache_ctrl.sv
hw/line_store.sv
hw/mem_port.sv
hw/cache_top.sv
tb/mem_model.sv
tb/tb_cache.sv

//--- tb/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_params.svh"

module mem_model (
    input  wire logic                clk,
    input  wire logic                proc_reset,
    input  wire logic                mem_read,
    input  wire logic                mem_write,
    input  wire bus_pkg::mem_addr_t  mem_addr,
    input  wire bus_pkg::line_t      mem_wdata,
    output logic                     mem_ready,
    output bus_pkg::line_t           mem_rdata
);
    import bus_pkg::*;

    line_t     store [mem_addr_t];
    mem_addr_t addr;
    line_t     wdata;
    logic      is_write;
    int        delay;

    // each word holds its word address xor 5a5a0000 until written
    function automatic line_t untouched_line(input mem_addr_t a);
        line_t l;
        for (int w = 0; w < `WORDS_PER_LINE; w++) begin
            l[w*`WORD_WIDTH +: `WORD_WIDTH] = {2'b00, a, w[1:0]} ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (!proc_reset && (mem_read || mem_write)) begin
                addr     = mem_addr;
                wdata    = mem_wdata;
                is_write = mem_write;
                delay    = $urandom_range(4, 1);
                repeat (delay - 1) @(posedge clk);
                #1;
                if (is_write) begin
                    store[addr] = wdata;
                end else if (store.exists(addr)) begin
                    mem_rdata = store[addr];
                end else begin
                    mem_rdata = untouched_line(addr);
                end
                mem_ready = 1'b1;
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
                // request stays up one more edge while the cache registers ready
                @(posedge clk);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache;
    import cache_pkg::*;
    import bus_pkg::*;

    localparam int WAIT_LIMIT = 100;
    localparam proc_addr_t ADDR_A = {25'h0a1b2c3, 3'd2, 2'd0};
    // same index as A but another tag
    localparam proc_addr_t ADDR_B = {25'h1f0e0d1, 3'd2, 2'd0};
    localparam proc_addr_t ADDR_C = {25'h0034567, 3'd5, 2'd2};

    logic       clk;
    logic       proc_reset;
    logic       proc_read;
    logic       proc_write;
    proc_addr_t proc_addr;
    word_t      proc_wdata;
    logic       proc_stall;
    word_t      proc_rdata;
    logic       mem_read;
    logic       mem_write;
    mem_addr_t  mem_addr;
    line_t      mem_wdata;
    logic       mem_ready;
    line_t      mem_rdata;

    int checks = 0;
    int errors = 0;
    int test_base = 0;
    int err_both = 0;
    int err_rd_stable = 0;
    int err_wr_stable = 0;
    int err_stall = 0;

    // bus monitor state
    int        read_starts = 0;
    int        write_starts = 0;
    int        seq = 0;
    int        read_seq = 0;
    int        write_seq = 0;
    logic      read_prev = 1'b0;
    logic      write_prev = 1'b0;
    mem_addr_t read_addr;
    mem_addr_t write_addr;
    line_t     write_data;

    word_t ref_mem [proc_addr_t];

    cache_top DUT (.*);
    mem_model u_mem_model (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        if (!proc_reset && mem_read && !read_prev) begin
            read_starts++;
            seq++;
            read_seq  = seq;
            read_addr = mem_addr;
        end
        if (!proc_reset && mem_write && !write_prev) begin
            write_starts++;
            seq++;
            write_seq  = seq;
            write_addr = mem_addr;
            write_data = mem_wdata;
        end
        read_prev  = mem_read;
        write_prev = mem_write;
    end

    assert property (@(posedge clk) disable iff (proc_reset) !(mem_read && mem_write))
        else begin
            $display("mem_read and mem_write were high together");
            err_both++;
        end

    assert property (@(posedge clk) disable iff (proc_reset)
        (mem_read && $past(mem_read) && !$past(mem_ready)) |-> mem_addr == $past(mem_addr))
        else begin
            $display("mem_addr changed while a read waited for mem_ready");
            err_rd_stable++;
        end

    assert property (@(posedge clk) disable iff (proc_reset)
        (mem_write && $past(mem_write) && !$past(mem_ready))
        |-> (mem_addr == $past(mem_addr)) && (mem_wdata == $past(mem_wdata)))
        else begin
            $display("mem_addr or mem_wdata changed while a write waited for mem_ready");
            err_wr_stable++;
        end

    assert property (@(posedge clk) disable iff (proc_reset) !(!proc_stall && !$past(proc_stall)))
        else begin
            $display("proc_stall stayed low for two cycles");
            err_stall++;
        end

    function automatic word_t expected_word(input proc_addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return {2'b00, a} ^ 32'h5a5a0000;
    endfunction

    function automatic int total_errors();
        return errors + err_both + err_rd_stable + err_wr_stable + err_stall;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        assert (actual === expected)
            else begin
                $display("FAILED %s: expected %h, got %h", name, expected, actual);
                errors++;
            end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond)
            else begin
                $display("check failed: %s", what);
                errors++;
            end
    endtask

    task automatic abort_run(input string why);
        $display("timeout: %s", why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic access(input logic wr, input proc_addr_t a, input word_t d,
                          output word_t rdata);
        int cycles;
        cycles     = 0;
        proc_read  = !wr;
        proc_write = wr;
        proc_addr  = a;
        proc_wdata = d;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                abort_run("proc_stall never fell for the request");
            end
        end while (proc_stall);
        rdata = proc_rdata;
        if (wr) begin
            ref_mem[a] = d;
        end
        // hold through the answer cycle
        @(posedge clk);
        #1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
    endtask

    task automatic read_check(input proc_addr_t a);
        word_t got;
        access(1'b0, a, '0, got);
        check_value("proc_rdata", expected_word(a), got);
    endtask

    task automatic end_test(input string name);
        int now_errors;
        now_errors = total_errors();
        if (now_errors == test_base) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed, %0d errors", name, now_errors - test_base);
        end
        test_base = now_errors;
    endtask

    initial begin
        word_t d1;
        word_t d2;
        word_t junk;
        int    rd0;
        int    wr0;
        int    seq0;
        void'($urandom(49383));
        clk        = 1'b0;
        proc_reset = 1'b1;
        proc_read  = 1'b0;
        proc_write = 1'b0;
        proc_addr  = '0;
        proc_wdata = '0;
        repeat (4) @(posedge clk);
        #1;
        proc_reset = 1'b0;

        check_value("mem_read", 32'h0, 32'(mem_read));
        check_value("mem_write", 32'h0, 32'(mem_write));
        check_value("proc_stall", 32'h1, 32'(proc_stall));
        rd0 = read_starts;
        read_check(ADDR_A);
        check_value("mem_read count", 32'(rd0 + 1), 32'(read_starts));
        check_value("mem_addr", 32'(ADDR_A[29:2]), 32'(read_addr));
        end_test("test 1 reset and first read miss");

        rd0 = read_starts;
        for (int w = 0; w < 4; w++) begin
            read_check({ADDR_A[29:2], 2'(w)});
        end
        check_value("mem_read count", 32'(rd0), 32'(read_starts));
        end_test("test 2 read hits on a filled line");

        rd0 = read_starts;
        wr0 = write_starts;
        d1  = $urandom;
        access(1'b1, {ADDR_A[29:2], 2'd3}, d1, junk);
        read_check({ADDR_A[29:2], 2'd3});
        check_value("mem_read count", 32'(rd0), 32'(read_starts));
        check_value("mem_write count", 32'(wr0), 32'(write_starts));
        end_test("test 3 write hit then read");

        seq0 = seq;
        rd0  = read_starts;
        wr0  = write_starts;
        read_check(ADDR_B);
        check_value("mem_write count", 32'(wr0 + 1), 32'(write_starts));
        check_value("mem_read count", 32'(rd0 + 1), 32'(read_starts));
        check_value("mem_addr", 32'(ADDR_A[29:2]), 32'(write_addr));
        check_value("mem_wdata word 3", d1, write_data[3*32 +: 32]);
        check_true(write_seq > seq0 && read_seq > write_seq,
                   "the refill did not wait for the write-back");
        rd0 = read_starts;
        read_check({ADDR_A[29:2], 2'd3});
        check_value("mem_read count", 32'(rd0 + 1), 32'(read_starts));
        end_test("test 4 dirty victim write-back");

        rd0 = read_starts;
        wr0 = write_starts;
        d2  = $urandom;
        access(1'b1, ADDR_C, d2, junk);
        check_value("mem_read count", 32'(rd0 + 1), 32'(read_starts));
        check_value("mem_write count", 32'(wr0), 32'(write_starts));
        rd0 = read_starts;
        for (int w = 0; w < 4; w++) begin
            read_check({ADDR_C[29:2], 2'(w)});
        end
        check_value("mem_read count", 32'(rd0), 32'(read_starts));
        end_test("test 5 write miss merge");

        $display("test 6 protocol assertions: %0d failures",
                 err_both + err_rd_stable + err_wr_stable + err_stall);
        $display("%0d value checks, %0d errors", checks, total_errors());
        if (total_errors() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
